// File: fcore.f
design/fcore_pkg.sv
design/issue_bus_if.sv
design/control_unit.sv
design/instruction_store.sv
design/decoder.sv
design/register_file.sv
design/executor.sv
design/fcore.sv
bench/fcore_tb.sv

// File: bench/fcore_tb.sv
module fcore_tb import fcore_pkg::*; ();

    localparam int MAX_CHANNELS = 4;
    localparam int PROGRAM_DEPTH = 256;
    localparam int NUM_RUNS = 3;
    localparam int MAX_PROG_WORDS = 100;
    localparam int WATCHDOG_CYCLES = 40 * MAX_PROG_WORDS * MAX_CHANNELS * NUM_RUNS + 20000;

    logic        clock;
    logic        rst_n;
    logic        run;
    logic [2:0]  n_channels;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        host_we;
    logic [5:0]  host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        busy;
    logic        done;

    integer      seed = 32'heef8_0f57;
    int          done_count = 0;
    int          n_instr;
    logic [4:0]  prog_op [64];
    logic [3:0]  prog_rd [64];
    logic [3:0]  prog_ra [64];
    logic [3:0]  prog_rb [64];
    logic [15:0] prog_imm [64];
    logic [31:0] model_regs [MAX_CHANNELS][16];

    fcore #(.MAX_CHANNELS(MAX_CHANNELS), .PROGRAM_DEPTH(PROGRAM_DEPTH)) DUT (
        .clock(clock), .rst_n(rst_n), .run(run), .n_channels(n_channels),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .busy(busy), .done(done)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Counts every cycle with done high
    always @(negedge clock) begin
        if (done === 1'b1) begin
            done_count = done_count + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: done never arrived within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking and host access
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic write_register(input int addr, input logic [31:0] value);
        @(posedge clock);
        host_we <= 1'b1;
        host_addr <= 6'(addr);
        host_wdata <= value;
        @(posedge clock);
        host_we <= 1'b0;
    endtask

    // Readback is registered, so sample a cycle after the address
    task automatic read_register(input int addr, output logic [31:0] value);
        @(posedge clock);
        host_addr <= 6'(addr);
        @(posedge clock);
        @(negedge clock);
        value = host_rdata;
    endtask

    task automatic check_all_registers(input string name);
        logic [31:0] value;
        for (int c = 0; c < MAX_CHANNELS; c++) begin
            for (int r = 0; r < 16; r++) begin
                read_register(c * 16 + r, value);
                check_value($sformatf("%s ch%0d r%0d", name, c, r), model_regs[c][r], value);
            end
        end
    endtask

    task automatic preload_registers();
        logic [31:0] value;
        for (int c = 0; c < MAX_CHANNELS; c++) begin
            for (int r = 0; r < 16; r++) begin
                value = $random(seed);
                write_register(c * 16 + r, value);
                model_regs[c][r] = value;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program generation and reference model
    ////////////////////////////////////////////////////////////////////////////

    // The first nine instructions cover every opcode once
    task automatic generate_program(input int count);
        logic [4:0] ops [9];
        int         pick;
        ops = '{LDI, ADD, SUB, MUL, AND, OR, XOR, SHL, SHR};
        n_instr = count;
        for (int i = 0; i < count; i++) begin
            pick = (i < 9) ? i : $unsigned($random(seed)) % 9;
            prog_op[i] = ops[pick];
            prog_rd[i] = 4'($random(seed));
            prog_ra[i] = 4'($random(seed));
            prog_rb[i] = 4'($random(seed));
            prog_imm[i] = 16'($random(seed));
        end
    endtask

    function automatic logic [31:0] encode_instruction(input int i);
        if (prog_op[i] == LDI) begin
            return {prog_op[i], prog_rd[i], 7'd0, prog_imm[i]};
        end
        return {prog_op[i], prog_rd[i], prog_ra[i], prog_rb[i], 15'd0};
    endfunction

    task automatic write_program_word(input int addr, input logic [31:0] word);
        @(posedge clock);
        prog_we <= 1'b1;
        prog_addr <= 8'(addr);
        prog_data <= word;
        @(posedge clock);
        prog_we <= 1'b0;
    endtask

    // Three NOPs after each instruction keep results three positions ahead of use
    task automatic load_program();
        int addr;
        addr = 0;
        for (int i = 0; i < n_instr; i++) begin
            write_program_word(addr, encode_instruction(i));
            addr++;
            repeat (3) begin
                write_program_word(addr, {NOP, 27'd0});
                addr++;
            end
        end
        write_program_word(addr, {STOP, 27'd0});
        // The two words fetched behind STOP must never execute
        for (int k = 1; k <= 2; k++) begin
            write_program_word(addr + k, {LDI, 4'($random(seed)), 7'd0, 16'($random(seed))});
        end
    endtask

    function automatic logic [31:0] expected_result(input logic [4:0] op, input logic [31:0] a,
                                                    input logic [31:0] b, input logic [15:0] imm);
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            MUL: return a * b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            SHL: return a << b[4:0];
            SHR: return a >> b[4:0];
            LDI: return {{16{imm[15]}}, imm};
            default: return 32'd0;
        endcase
    endfunction

    task automatic apply_program_to_model(input int channels);
        for (int c = 0; c < channels; c++) begin
            for (int i = 0; i < n_instr; i++) begin
                model_regs[c][prog_rd[i]] = expected_result(prog_op[i],
                    model_regs[c][prog_ra[i]], model_regs[c][prog_rb[i]], prog_imm[i]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run sequencing
    ////////////////////////////////////////////////////////////////////////////

    // Optionally sends a second run pulse and a host write while busy
    task automatic run_core(input int channels, input bit disturb);
        int start_count;
        start_count = done_count;
        @(posedge clock);
        run <= 1'b1;
        n_channels <= 3'(channels);
        @(posedge clock);
        run <= 1'b0;
        @(negedge clock);
        check_value("busy after run", 32'd1, {31'd0, busy});
        if (disturb) begin
            @(posedge clock);
            run <= 1'b1;
            host_we <= 1'b1;
            // Aimed at a channel outside the run so the program never overwrites it
            host_addr <= 6'(channels * 16
                            + $unsigned($random(seed)) % ((MAX_CHANNELS - channels) * 16));
            host_wdata <= $random(seed);
            @(posedge clock);
            run <= 1'b0;
            host_we <= 1'b0;
            @(negedge clock);
        end
        while (done !== 1'b1) @(negedge clock);
        repeat (5) @(negedge clock);
        check_value("done pulses per run", start_count + 1, done_count);
        check_value("busy after done", 32'd0, {31'd0, busy});
    endtask

    initial begin
        rst_n = 1'b0;
        run = 1'b0;
        n_channels = 3'd1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        for (int c = 0; c < MAX_CHANNELS; c++) begin
            for (int r = 0; r < 16; r++) begin
                model_regs[c][r] = '0;
            end
        end
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        @(negedge clock);
        check_value("reset busy", 32'd0, {31'd0, busy});
        check_value("reset done", 32'd0, {31'd0, done});
        check_all_registers("reset");

        preload_registers();
        check_all_registers("host readback");

        generate_program(24);
        load_program();
        run_core(1, 1'b0);
        apply_program_to_model(1);
        check_all_registers("single channel");

        preload_registers();
        generate_program(20);
        load_program();
        run_core(4, 1'b0);
        apply_program_to_model(4);
        check_all_registers("four channels");

        // Continues from the state left by the previous run
        generate_program(16);
        load_program();
        run_core(2, 1'b1);
        apply_program_to_model(2);
        check_all_registers("reprogrammed");

        $display("** PASS **");
        $finish;
    end

endmodule

// File: design/fcore.sv
module fcore import fcore_pkg::*; #(
    parameter int MAX_CHANNELS = 4,
    parameter int PROGRAM_DEPTH = 256,
    localparam int CH_WIDTH = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1,
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH),
    localparam int ADDR_WIDTH = CH_WIDTH + REG_WIDTH
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic [CH_WIDTH:0]     n_channels,
    input  logic                  prog_we,
    input  logic [PC_WIDTH-1:0]   prog_addr,
    input  logic [DATA_WIDTH-1:0] prog_data,
    input  logic                  host_we,
    input  logic [ADDR_WIDTH-1:0] host_addr,
    input  logic [DATA_WIDTH-1:0] host_wdata,
    output logic [DATA_WIDTH-1:0] host_rdata,
    output logic                  busy,
    output logic                  done
);

    logic [PC_WIDTH-1:0]   pc;
    logic                  fetch_enable;
    logic [DATA_WIDTH-1:0] fetch_data;
    logic [CH_WIDTH-1:0]   channel;
    logic                  stop_seen;
    logic                  result_we;
    logic [ADDR_WIDTH-1:0] result_addr;
    logic [DATA_WIDTH-1:0] result_data;

    issue_bus_if #(.MAX_CHANNELS(MAX_CHANNELS)) issue_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing and fetch
    ////////////////////////////////////////////////////////////////////////////

    control_unit #(
        .MAX_CHANNELS(MAX_CHANNELS),
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) u_control_unit (
        .clock(clock),
        .rst_n(rst_n),
        .run(run),
        .n_channels(n_channels),
        .stop_seen(stop_seen),
        .pc(pc),
        .fetch_enable(fetch_enable),
        .channel(channel),
        .busy(busy),
        .done(done)
    );

    instruction_store #(
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) u_instruction_store (
        .clock(clock),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .fetch_enable(fetch_enable),
        .pc(pc),
        .fetch_data(fetch_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Decode, operand read, execute
    ////////////////////////////////////////////////////////////////////////////

    decoder #(
        .MAX_CHANNELS(MAX_CHANNELS)
    ) u_decoder (
        .clock(clock),
        .rst_n(rst_n),
        .fetch_valid(fetch_enable),
        .fetch_data(fetch_data),
        .channel(channel),
        .stop_seen(stop_seen),
        .bus(issue_bus.decoder_side)
    );

    register_file #(
        .MAX_CHANNELS(MAX_CHANNELS)
    ) u_register_file (
        .clock(clock),
        .rst_n(rst_n),
        .busy(busy),
        .bus(issue_bus.register_side),
        .result_we(result_we),
        .result_addr(result_addr),
        .result_data(result_data),
        .host_we(host_we),
        .host_addr(host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata)
    );

    executor #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_executor (
        .clock(clock),
        .rst_n(rst_n),
        .bus(issue_bus.executor_side),
        .result_we(result_we),
        .result_addr(result_addr),
        .result_data(result_data)
    );

endmodule

// File: design/executor.sv
module executor import fcore_pkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clock,
    input  logic                  rst_n,
    issue_bus_if.executor_side    bus,
    output logic                  result_we,
    output logic [ADDR_WIDTH-1:0] result_addr,
    output logic [DATA_WIDTH-1:0] result_data
);

    localparam int SHIFT_WIDTH = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0]  alu_out;
    logic [SHIFT_WIDTH-1:0] shift;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    // Shift amount is operand b modulo the word width
    assign shift = bus.operand_b[SHIFT_WIDTH-1:0];

    always_comb begin
        case (bus.opcode)
            ADD: alu_out = bus.operand_a + bus.operand_b;
            SUB: alu_out = bus.operand_a - bus.operand_b;
            MUL: alu_out = bus.operand_a * bus.operand_b;
            AND: alu_out = bus.operand_a & bus.operand_b;
            OR:  alu_out = bus.operand_a | bus.operand_b;
            XOR: alu_out = bus.operand_a ^ bus.operand_b;
            SHL: alu_out = bus.operand_a << shift;
            SHR: alu_out = bus.operand_a >> shift;
            LDI: alu_out = bus.imm_value;
            default: alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result_we <= 1'b0;
        end else begin
            result_we <= bus.issue;
        end
    end

    // Payload only, qualified by result_we
    always_ff @(posedge clock) begin
        if (bus.issue) begin
            result_addr <= bus.dest;
            result_data <= alu_out;
        end
    end

endmodule

// File: design/register_file.sv
module register_file import fcore_pkg::*; #(
    parameter int MAX_CHANNELS = 4,
    localparam int CH_WIDTH = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1,
    localparam int ADDR_WIDTH = CH_WIDTH + REG_WIDTH,
    localparam int DEPTH = MAX_CHANNELS * REGS_PER_CHANNEL
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  busy,
    issue_bus_if.register_side    bus,
    input  logic                  result_we,
    input  logic [ADDR_WIDTH-1:0] result_addr,
    input  logic [DATA_WIDTH-1:0] result_data,
    input  logic                  host_we,
    input  logic [ADDR_WIDTH-1:0] host_addr,
    input  logic [DATA_WIDTH-1:0] host_wdata,
    output logic [DATA_WIDTH-1:0] host_rdata
);

    // Channel number forms the upper address bits
    logic [DATA_WIDTH-1:0] regs [DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Operand reads
    ////////////////////////////////////////////////////////////////////////////

    assign bus.operand_a = regs[bus.addr_a];
    assign bus.operand_b = regs[bus.addr_b];

    ////////////////////////////////////////////////////////////////////////////
    // Write ports and host readback
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
            host_rdata <= '0;
        end else begin
            // Core owns the array during a run, the host owns it otherwise
            if (busy) begin
                if (result_we) begin
                    regs[result_addr] <= result_data;
                end
            end else if (host_we) begin
                regs[host_addr] <= host_wdata;
            end
            host_rdata <= regs[host_addr];
        end
    end

endmodule

// File: design/decoder.sv
module decoder import fcore_pkg::*; #(
    parameter int MAX_CHANNELS = 4,
    localparam int CH_WIDTH = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                fetch_valid,
    input  instr_u              fetch_data,
    input  logic [CH_WIDTH-1:0] channel,
    output logic                stop_seen,
    issue_bus_if.decoder_side   bus
);

    logic       fetch_pending;
    logic       word_valid;
    instr_u     word;
    logic [1:0] squash_count;
    logic       squashing;
    logic       executable;
    opcode_e    opcode;

    localparam int IMM_WIDTH = $bits(word.i.imm);

    ////////////////////////////////////////////////////////////////////////////
    // Fetch tracking
    ////////////////////////////////////////////////////////////////////////////

    // Store data lags the fetch request by one cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pending <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            fetch_pending <= fetch_valid;
            word_valid <= fetch_pending;
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_pending) begin
            word <= fetch_data;
        end
    end

    // Opcode and rd positions are shared by both views
    assign opcode = word.r.opcode;

    ////////////////////////////////////////////////////////////////////////////
    // Squash after STOP
    ////////////////////////////////////////////////////////////////////////////

    assign squashing = (squash_count != 2'd0);
    assign stop_seen = word_valid && !squashing && (opcode == STOP);

    // Two words behind STOP were already requested from the store
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            squash_count <= 2'd0;
        end else if (stop_seen) begin
            squash_count <= 2'd2;
        end else if (word_valid && squashing) begin
            squash_count <= squash_count - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode and issue
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        bus.opcode = opcode;
        bus.addr_a = {channel, word.r.ra};
        bus.addr_b = {channel, word.r.rb};
        bus.dest = {channel, word.r.rd};
        bus.imm_value = {{(DATA_WIDTH - IMM_WIDTH){word.i.imm[IMM_WIDTH-1]}}, word.i.imm};
        executable = 1'b0;
        case (opcode)
            ADD, SUB, MUL, AND, OR, XOR, SHL, SHR, LDI: begin
                executable = 1'b1;
            end
            // NOP, STOP and unknown codes never reach the executor
            default: begin
                executable = 1'b0;
            end
        endcase
        bus.issue = word_valid && !squashing && executable;
    end

endmodule

// File: design/instruction_store.sv
module instruction_store import fcore_pkg::*; #(
    parameter int PROGRAM_DEPTH = 256,
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH)
) (
    input  logic                  clock,
    input  logic                  prog_we,
    input  logic [PC_WIDTH-1:0]   prog_addr,
    input  logic [DATA_WIDTH-1:0] prog_data,
    input  logic                  fetch_enable,
    input  logic [PC_WIDTH-1:0]   pc,
    output logic [DATA_WIDTH-1:0] fetch_data
);

    logic [DATA_WIDTH-1:0] mem [PROGRAM_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Host load port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch port
    ////////////////////////////////////////////////////////////////////////////

    // Registered read, word at pc shows up one cycle after the request
    always_ff @(posedge clock) begin
        if (fetch_enable) begin
            fetch_data <= mem[pc];
        end
    end

endmodule

// File: design/control_unit.sv
module control_unit #(
    parameter int MAX_CHANNELS = 4,
    parameter int PROGRAM_DEPTH = 256,
    localparam int CH_WIDTH = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1,
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH)
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                run,
    input  logic [CH_WIDTH:0]   n_channels,
    input  logic                stop_seen,
    output logic [PC_WIDTH-1:0] pc,
    output logic                fetch_enable,
    output logic [CH_WIDTH-1:0] channel,
    output logic                busy,
    output logic                done
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } state_e;

    state_e              state;
    logic [1:0]          drain_count;
    logic [CH_WIDTH:0]   active_channels;
    logic [CH_WIDTH:0]   requested;
    logic                last_channel;
    logic [PC_WIDTH-1:0] pc_next;

    // Zero channels behaves as one, too many is clamped
    always_comb begin
        if (n_channels == '0) begin
            requested = (CH_WIDTH + 1)'(1);
        end else if (n_channels > (CH_WIDTH + 1)'(MAX_CHANNELS)) begin
            requested = (CH_WIDTH + 1)'(MAX_CHANNELS);
        end else begin
            requested = n_channels;
        end
    end

    assign last_channel = (({1'b0, channel} + 1'b1) == active_channels);
    assign pc_next = (pc == PC_WIDTH'(PROGRAM_DEPTH - 1)) ? '0 : pc + 1'b1;

    assign fetch_enable = (state == FETCH);
    assign busy = (state != IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // Run sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pc <= '0;
            channel <= '0;
            drain_count <= '0;
            active_channels <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (run) begin
                        active_channels <= requested;
                        pc <= '0;
                        channel <= '0;
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    pc <= pc_next;
                    if (stop_seen) begin
                        drain_count <= '0;
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Three cycles let the last result reach the array
                    if (drain_count == 2'd2) begin
                        if (last_channel) begin
                            done <= 1'b1;
                            state <= IDLE;
                        end else begin
                            channel <= channel + 1'b1;
                            pc <= '0;
                            state <= FETCH;
                        end
                    end else begin
                        drain_count <= drain_count + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/issue_bus_if.sv
interface issue_bus_if import fcore_pkg::*; #(
    parameter int MAX_CHANNELS = 4
);

    localparam int CH_WIDTH = (MAX_CHANNELS > 1) ? $clog2(MAX_CHANNELS) : 1;
    localparam int ADDR_WIDTH = CH_WIDTH + REG_WIDTH;

    // Operation strobe and decoded fields
    logic                  issue;
    opcode_e               opcode;
    logic [ADDR_WIDTH-1:0] dest;
    logic [DATA_WIDTH-1:0] imm_value;

    // Operand addresses and the data read back for them
    logic [ADDR_WIDTH-1:0] addr_a;
    logic [ADDR_WIDTH-1:0] addr_b;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;

    modport decoder_side (
        output issue,
        output opcode,
        output dest,
        output imm_value,
        output addr_a,
        output addr_b
    );

    modport register_side (
        input  addr_a,
        input  addr_b,
        output operand_a,
        output operand_b
    );

    modport executor_side (
        input issue,
        input opcode,
        input dest,
        input imm_value,
        input operand_a,
        input operand_b
    );

endinterface

// File: design/fcore_pkg.sv
package fcore_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath and instruction geometry
    ////////////////////////////////////////////////////////////////////////////

    // Datapath and instruction word share one width
    localparam int DATA_WIDTH = 32;
    localparam int OPCODE_WIDTH = 5;

    // Registers visible to a single channel
    localparam int REGS_PER_CHANNEL = 16;
    localparam int REG_WIDTH = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP  = 5'd0,
        ADD  = 5'd1,
        SUB  = 5'd2,
        MUL  = 5'd3,
        AND  = 5'd4,
        OR   = 5'd5,
        XOR  = 5'd6,
        SHL  = 5'd7,
        SHR  = 5'd8,
        LDI  = 5'd9,
        STOP = 5'd10
    } opcode_e;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////////////////////

    // Register form: rd = ra op rb
    typedef struct packed {
        opcode_e              opcode;
        logic [REG_WIDTH-1:0] rd;
        logic [REG_WIDTH-1:0] ra;
        logic [REG_WIDTH-1:0] rb;
        logic [14:0]          unused;
    } reg_form_t;

    // Immediate form: rd = sign extended imm
    typedef struct packed {
        opcode_e              opcode;
        logic [REG_WIDTH-1:0] rd;
        logic [6:0]           unused;
        logic [15:0]          imm;
    } imm_form_t;

    // Same word, two views; the opcode sits in the same bits in both
    typedef union packed {
        reg_form_t r;
        imm_form_t i;
    } instr_u;

endpackage
